/* project.f */
+incdir+src
src/nobl_pkg.sv
src/nobl_cmd_decode.sv
src/nobl_write_path.sv
src/nobl_read_path.sv
src/nobl_mem_array.sv
src/nobl_sram_top.sv
tb/nobl_sram_asserts.sv
tb/tb_nobl_sram.sv

/* run_sim.sh */
#!/bin/bash
# build and run the NoBL SRAM testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f project.f --top-module tb_nobl_sram \
  -o tb_nobl_sram && ./obj_dir/tb_nobl_sram 2>&1 | tee sim.log \
  || { echo "build or run failed"; exit 1; }

# pass only with the pass line present and no fail line
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; } || \
  grep -q "No errors" sim.log && { echo "PASS"; exit 0; } || \
  { echo "FAIL"; exit 1; }

/* tb/tb_nobl_sram.sv */
/*
  Testbench for the NoBL SRAM. A cycle model tracks the command pipeline
  and a reference memory. Memory is filled first so every read is defined.
*/
`default_nettype none
`timescale 1ns/100ps

`include "nobl_defines.svh"

module tb_nobl_sram
  import nobl_pkg::*;
();

  typedef struct packed {
    logic  vld;  // q_o carries a read word
    data_t q;
  } exp_t;

  // sum of all test lengths in cycles, doubled for the watchdog
  localparam int TEST_CYCLES = 10 + 1027 + 19 + 99 + 35 + 63 + 41 + 303;

  logic clk = 1'b0;
  logic rst_n, cen_n, adv_ld_n, we_n, ce1_n, ce2, ce3_n, oe_n, mode;
  addr_t a;
  bmask_t bws_n;
  data_t d, q;
  logic q_oe;

  data_t ref_mem [addr_t];  // reference memory
  exp_t exp_q [$];          // one entry per edge
  exp_t last_exp;
  nobl_op_e m_op;           // model of the decoder state
  bmask_t m_mask;
  addr_t m_base;
  logic [1:0] m_k;          // beat inside the burst
  nobl_op_e h_op [3];       // commands of the last three edges
  addr_t h_addr [3];
  bmask_t h_mask [3];
  data_t h_data [3];
  logic [31:0] lfsr_q;
  int errors = 0;
  int checks = 0;
  int err_mark = 0;

  always #10 clk = ~clk;

  nobl_sram_top dut_i (
    .clk (clk), .rst_n_i (rst_n), .cen_n_i (cen_n), .adv_ld_n_i (adv_ld_n),
    .we_n_i (we_n), .ce1_n_i (ce1_n), .ce2_i (ce2), .ce3_n_i (ce3_n),
    .oe_n_i (oe_n), .mode_i (mode), .a_i (a), .bws_n_i (bws_n), .d_i (d),
    .q_o (q), .q_oe_o (q_oe)
  );

  // ********************************************************************
  // reference functions
  // ********************************************************************

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic rand_bit();
    logic [31:0] r;
    r = rand_bits(1);
    return r[0];
  endfunction

  // linear counts up, interleaved xors the beat into the start
  function automatic addr_t burst_addr(input addr_t base, input logic [1:0] k, input logic ilv);
    addr_t r;
    r = base;
    if (ilv)
      r[1:0] = base[1:0] ^ k;
    else
      r[1:0] = base[1:0] + k;
    return r;
  endfunction

  function automatic data_t ref_word(input addr_t ad);
    return ref_mem.exists(ad) ? ref_mem[ad] : 'x;
  endfunction

  task automatic store_word(input addr_t ad, input bmask_t m, input data_t wd);
    data_t w;
    w = ref_mem.exists(ad) ? ref_mem[ad] : '0;
    for (int b = 0; b < `NOBL_BYTES; b++)
    begin
      if (m[b])
        w[b*`NOBL_BYTE_W +: `NOBL_BYTE_W] = wd[b*`NOBL_BYTE_W +: `NOBL_BYTE_W];
    end
    ref_mem[ad] = w;
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] expv);
    checks++;
    if (got !== expv)
    begin
      $display("Fail %s: got %h expected %h at %0t", name, got, expv, $time);
      errors++;
    end
  endtask

  // ********************************************************************
  // stimulus, one call per clock
  // ********************************************************************

  task automatic do_cycle(input logic cen, input logic adv, input logic we,
                          input logic [2:0] ce, input addr_t ad, input bmask_t bws,
                          input data_t wd);
    cen_n = cen;
    adv_ld_n = adv;
    we_n = we;
    {ce1_n, ce2, ce3_n} = ce;
    a = ad;
    bws_n = bws;
    d = h_data[1];  // data of the command two edges back
    @(posedge clk);
    if (!cen)
    begin
      if (!adv)
      begin
        if (ce == 3'b010)
        begin
          m_op = we ? OP_READ : OP_WRITE;
          m_mask = we ? 2'b00 : ~bws;
        end
        else
        begin
          m_op = OP_DESEL;
          m_mask = '0;
        end
        m_base = ad;
        m_k = 2'd0;
      end
      else
        m_k = m_k + 2'd1;
      for (int i = 2; i > 0; i--)
      begin
        h_op[i] = h_op[i-1];
        h_addr[i] = h_addr[i-1];
        h_mask[i] = h_mask[i-1];
        h_data[i] = h_data[i-1];
      end
      h_op[0] = m_op;
      h_addr[0] = burst_addr(m_base, m_k, mode);
      h_mask[0] = m_mask;
      h_data[0] = wd;
      if (h_op[2] == OP_WRITE)
        store_word(h_addr[2], h_mask[2], h_data[2]);
      last_exp.vld = (h_op[2] == OP_READ);
      last_exp.q = last_exp.vld ? ref_word(h_addr[2]) : '0;
    end
    exp_q.push_back(last_exp);  // a stall repeats the previous result
    #2;
  endtask

  task automatic write_cmd(input addr_t ad, input bmask_t bws, input data_t wd);
    do_cycle(1'b0, 1'b0, 1'b0, 3'b010, ad, bws, wd);
  endtask

  task automatic read_cmd(input addr_t ad);
    do_cycle(1'b0, 1'b0, 1'b1, 3'b010, ad, 2'b11, '0);
  endtask

  task automatic burst_cmd(input data_t wd);
    do_cycle(1'b0, 1'b1, 1'b1, 3'b010, '0, 2'b11, wd);
  endtask

  task automatic idle(input int n);
    repeat (n) do_cycle(1'b0, 1'b0, 1'b1, 3'b110, '0, 2'b11, '0);
  endtask

  task automatic end_test(input string name);
    idle(3);
    $display("test %-10s %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  // compare a little after each edge, outputs are settled there
  initial
  begin
    exp_t e;
    forever
    begin
      @(posedge clk);
      #1;
      while (exp_q.size() > 0)
      begin
        e = exp_q.pop_front();
        check("q_oe_o", 32'(q_oe), 32'(e.vld & ~oe_n));
        if (e.vld)
          check("q_o", 32'(q), 32'(e.q));
      end
    end
  end

  initial
  begin
    #(TEST_CYCLES * 2 * 20);
    $display("watchdog expired before the tests finished");
    $display("Errors found");
    $finish;
  end

  // ********************************************************************
  // tests
  // ********************************************************************

  initial
  begin
    addr_t ads [8];
    addr_t ad;
    logic [2:0] ce_tab [3];
    logic [31:0] r;
    lfsr_q = 32'hf91b654f;
    rst_n = 1'b0;
    {cen_n, adv_ld_n, we_n, ce1_n, ce2, ce3_n, oe_n, mode} = 8'b0011_0100;
    a = '0;
    bws_n = 2'b11;
    d = '0;
    last_exp = '0;
    m_op = OP_DESEL;
    m_mask = '0;
    m_base = '0;
    m_k = 2'd0;
    for (int i = 0; i < 3; i++)
    begin
      h_op[i] = OP_DESEL;
      h_addr[i] = '0;
      h_mask[i] = '0;
      h_data[i] = '0;
    end
    repeat (8) @(posedge clk);
    #2 rst_n = 1'b1;

    for (int i = 0; i < 1024; i++)
      write_cmd(addr_t'(i), 2'b00, data_t'({addr_t'(i), ~i[7:0]}));
    end_test("fill");

    for (int i = 0; i < 8; i++)
    begin
      ads[i] = addr_t'(rand_bits(10));
      write_cmd(ads[i], bmask_t'(i), data_t'(rand_bits(18)));
    end
    for (int i = 0; i < 8; i++)
      read_cmd(ads[i]);
    end_test("masks");

    for (int md = 0; md < 2; md++)
    begin
      for (int s = 0; s < 4; s++)
      begin
        mode = md[0];
        ad = {8'(rand_bits(8)), s[1:0]};
        write_cmd(ad, 2'b00, data_t'(rand_bits(18)));
        repeat (3) burst_cmd(data_t'(rand_bits(18)));
        for (int k = 0; k < 4; k++)
          read_cmd(burst_addr(ad, 2'(k), mode));  // each beat on its own
        read_cmd(ad);
        repeat (3) burst_cmd('0);
      end
    end
    mode = 1'b0;
    end_test("bursts");

    for (int i = 0; i < 8; i++)
    begin
      ad = addr_t'(rand_bits(10));
      write_cmd(ad, 2'b00, data_t'(rand_bits(18)));
      read_cmd(ad);  // data still in flight
      write_cmd(ad, bmask_t'(rand_bits(2)), data_t'(rand_bits(18)));
      read_cmd(ad);
    end
    end_test("forward");

    for (int i = 0; i < 60; i++)
    begin
      r = rand_bits(3);
      if (r < 2)
        do_cycle(1'b1, 1'b1, 1'b1, 3'b010, '0, 2'b11, '0);
      else if (r[0])
        write_cmd(addr_t'(rand_bits(3)), bmask_t'(rand_bits(2)), data_t'(rand_bits(18)));
      else
        read_cmd(addr_t'(rand_bits(3)));
    end
    end_test("stall");

    ce_tab[0] = 3'b110;  // ce1_n off
    ce_tab[1] = 3'b000;  // ce2 off
    ce_tab[2] = 3'b011;  // ce3_n off
    for (int c = 0; c < 3; c++)
    begin
      ad = addr_t'(rand_bits(10));
      do_cycle(1'b0, 1'b0, 1'b0, ce_tab[c], ad, 2'b00, data_t'(rand_bits(18)));
      repeat (3) burst_cmd(data_t'(rand_bits(18)));
      read_cmd(ad);
      repeat (3) burst_cmd('0);
      idle(3);
    end
    oe_n = 1'b1;
    read_cmd(addr_t'(rand_bits(10)));
    read_cmd(addr_t'(rand_bits(10)));
    idle(3);
    oe_n = 1'b0;
    end_test("deselect");

    for (int i = 0; i < 300; i++)
    begin
      r = rand_bits(3);
      if (r == 0)
        do_cycle(1'b1, 1'b1, 1'b1, 3'b010, '0, 2'b11, '0);
      else if (r == 1)
        burst_cmd(data_t'(rand_bits(18)));
      else
      begin
        mode = rand_bit();  // only changed on loads
        do_cycle(1'b0, 1'b0, rand_bit(), (rand_bits(3) == 0) ? 3'b011 : 3'b010,
                 addr_t'(rand_bits(10)), bmask_t'(rand_bits(2)), data_t'(rand_bits(18)));
      end
    end
    end_test("random");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/nobl_sram_asserts.sv */
/*
  Concurrent checks on the SRAM outputs, bound to nobl_sram_top.
  Stall hold allows q_oe_o to move only when oe_n_i itself moved.
*/
`default_nettype none
`timescale 1ns/100ps

module nobl_sram_asserts
  import nobl_pkg::*;
(
  input wire logic  clk,
  input wire logic  rst_n_i,
  input wire logic  cen_n_i,
  input wire logic  oe_n_i,
  input wire data_t q_o,
  input wire logic  q_oe_o
);

  // drive enable never on while output enable is off
  oe_gate_a: assert property (@(posedge clk) disable iff (!rst_n_i) oe_n_i |-> !q_oe_o)
    else $error("q_oe_o high while oe_n_i high");

  // no drive during reset
  reset_quiet_a: assert property (@(posedge clk) !rst_n_i |-> !q_oe_o)
    else $error("q_oe_o high during reset");

  // a stalled edge freezes the output stage
  stall_hold_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    cen_n_i |=> $stable(q_o) && ($stable(q_oe_o) || $changed(oe_n_i)))
    else $error("outputs moved across a stalled edge");

endmodule

bind nobl_sram_top nobl_sram_asserts u_sram_asserts (
  .clk     (clk),
  .rst_n_i (rst_n_i),
  .cen_n_i (cen_n_i),
  .oe_n_i  (oe_n_i),
  .q_o     (q_o),
  .q_oe_o  (q_oe_o)
);

`default_nettype wire

/* src/nobl_sram_top.sv */
/*
  1K x 18 NoBL pipelined SRAM. Reads return data two enabled edges after
  the command, writes take data two enabled edges after it. The data bus
  is split into d_i, q_o and the drive enable q_oe_o.
*/
`default_nettype none
`timescale 1ns/100ps

module nobl_sram_top
  import nobl_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n_i,
  input  logic   cen_n_i,     // high freezes every stage
  input  logic   adv_ld_n_i,
  input  logic   we_n_i,
  input  logic   ce1_n_i,
  input  logic   ce2_i,
  input  logic   ce3_n_i,
  input  logic   oe_n_i,
  input  logic   mode_i,
  input  addr_t  a_i,
  input  bmask_t bws_n_i,
  input  data_t  d_i,
  output data_t  q_o,
  output logic   q_oe_o
);

  nobl_cmd_t cmd;      // registered command, one per edge
  wr_req_t   wr_req;   // write path to array
  data_t     rd_data;  // array read register

  nobl_cmd_decode u_cmd_decode (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .cen_n_i    (cen_n_i),
    .adv_ld_n_i (adv_ld_n_i),
    .we_n_i     (we_n_i),
    .ce1_n_i    (ce1_n_i),
    .ce2_i      (ce2_i),
    .ce3_n_i    (ce3_n_i),
    .mode_i     (mode_i),
    .a_i        (a_i),
    .bws_n_i    (bws_n_i),
    .cmd_o      (cmd)
  );

  nobl_write_path u_write_path (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .cen_n_i (cen_n_i),
    .cmd_i   (cmd),
    .d_i     (d_i),
    .wr_o    (wr_req)
  );

  nobl_read_path u_read_path (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .cen_n_i   (cen_n_i),
    .oe_n_i    (oe_n_i),
    .cmd_i     (cmd),
    .rd_data_i (rd_data),
    .q_o       (q_o),
    .q_oe_o    (q_oe_o)
  );

  // read address comes straight from the command register
  nobl_mem_array u_mem_array (
    .clk       (clk),
    .cen_n_i   (cen_n_i),
    .rd_addr_i (cmd.addr),
    .wr_i      (wr_req),
    .rd_data_o (rd_data)
  );

endmodule

`default_nettype wire

/* src/nobl_mem_array.sv */
/*
  1K x 18 storage with one byte-masked write port and one registered read
  port. A read and a write to the same word at the same edge returns the
  merged word. Contents are undefined until written.
*/
`default_nettype none
`timescale 1ns/100ps

`include "nobl_defines.svh"

module nobl_mem_array
  import nobl_pkg::*;
(
  input  logic    clk,
  input  logic    cen_n_i,
  input  addr_t   rd_addr_i,
  input  wr_req_t wr_i,
  output data_t   rd_data_o
);

  localparam int unsigned DEPTH = 1 << `NOBL_ADDR_W;
  localparam int unsigned BW    = `NOBL_BYTE_W;  // lane width

  data_t mem_q [DEPTH];
  data_t rd_word;  // array word with forwarded lanes
  data_t rd_q;     // registered read port
  logic  fwd_hit;  // same word written at this edge

  // ********************************************************************
  // write port
  // ********************************************************************

  always_ff @(posedge clk)
  begin
    if (!cen_n_i && wr_i.en)
    begin
      for (int b = 0; b < `NOBL_BYTES; b++)
      begin
        if (wr_i.bmask[b])
          mem_q[wr_i.addr][b*BW +: BW] <= wr_i.data[b*BW +: BW];
      end
    end
  end

  // ********************************************************************
  // read port with same-edge forwarding
  // ********************************************************************

  assign fwd_hit = wr_i.en && (wr_i.addr == rd_addr_i);

  always_comb
  begin
    rd_word = mem_q[rd_addr_i];
    for (int b = 0; b < `NOBL_BYTES; b++)
    begin
      if (fwd_hit && wr_i.bmask[b])
        rd_word[b*BW +: BW] = wr_i.data[b*BW +: BW];  // new lane wins
    end
  end

  always_ff @(posedge clk)
  begin
    if (!cen_n_i)
      rd_q <= rd_word;
  end

  assign rd_data_o = rd_q;

endmodule

`default_nettype wire

/* src/nobl_read_path.sv */
/*
  Read output stage. q_o is loaded at edge N+2 of a read and cleared for
  any other cycle. q_oe_o follows oe_n_i without a clock.
*/
`default_nettype none
`timescale 1ns/100ps

module nobl_read_path
  import nobl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      cen_n_i,
  input  logic      oe_n_i,     // async output enable, low active
  input  nobl_cmd_t cmd_i,
  input  data_t     rd_data_i,  // array read register
  output data_t     q_o,
  output logic      q_oe_o
);

  logic rd_v1_q;  // array register holds a read word
  logic rd_v2_q;  // q_o holds a read word

  // ********************************************************************
  // read valid pipeline, in step with the array
  // ********************************************************************

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rd_v1_q <= 1'b0;
      rd_v2_q <= 1'b0;
      q_o     <= '0;
    end
    else if (!cen_n_i)
    begin
      rd_v1_q <= (cmd_i.op == OP_READ);  // edge N+1
      rd_v2_q <= rd_v1_q;                // edge N+2
      if (rd_v1_q)
        q_o <= rd_data_i;
      else
        q_o <= '0;                       // writes and deselects park at zero
    end
  end

  // drive enable, stands in for the tristate control of the pins
  assign q_oe_o = rd_v2_q & ~oe_n_i;

endmodule

`default_nettype wire

/* src/nobl_write_path.sv */
/*
  Late-write path. A write command seen on cmd_i is held one edge, then
  joined with d_i. The request is only enabled while cen_n_i is low.
*/
`default_nettype none
`timescale 1ns/100ps

module nobl_write_path
  import nobl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      cen_n_i,
  input  nobl_cmd_t cmd_i,  // decoder output, command of edge N
  input  data_t     d_i,    // write data, taken at edge N+2
  output wr_req_t   wr_o
);

  logic   is_wr;        // current command is a write
  logic   pend_en_q;    // write waiting for its data
  addr_t  pend_addr_q;
  bmask_t pend_mask_q;

  assign is_wr = (cmd_i.op == OP_WRITE);

  // ********************************************************************
  // pending write, one stage
  // ********************************************************************

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      pend_en_q <= 1'b0;
    else if (!cen_n_i)
      pend_en_q <= is_wr;  // back to back writes refill every edge
  end

  // payload only moves on a write
  always_ff @(posedge clk)
  begin
    if (!cen_n_i && is_wr)
    begin
      pend_addr_q <= cmd_i.addr;
      pend_mask_q <= cmd_i.bmask;
    end
  end

  // request to the array, used at the next enabled edge
  always_comb
  begin
    wr_o.en    = pend_en_q & ~cen_n_i;  // a stalled edge stores nothing
    wr_o.addr  = pend_addr_q;
    wr_o.bmask = pend_mask_q;
    wr_o.data  = d_i;
  end

endmodule

`default_nettype wire

/* src/nobl_cmd_decode.sv */
/*
  Command register of the NoBL SRAM. A burst repeats the last loaded op and
  mask and steps only the low two address bits, wrapping inside the group.
  mode_i is sampled on every burst edge, not only at the load.
*/
`default_nettype none
`timescale 1ns/100ps

module nobl_cmd_decode
  import nobl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      cen_n_i,     // clock enable, low active
  input  logic      adv_ld_n_i,  // 1 = burst, 0 = load
  input  logic      we_n_i,
  input  logic      ce1_n_i,
  input  logic      ce2_i,
  input  logic      ce3_n_i,
  input  logic      mode_i,      // 1 = interleaved, 0 = linear
  input  addr_t     a_i,
  input  bmask_t    bws_n_i,     // byte write selects, low active
  output nobl_cmd_t cmd_o
);

  logic      sel;           // all three chip enables active
  nobl_op_e  load_op;       // op decoded from the pins
  bmask_t    load_mask;
  logic      linear;        // burst order for this edge
  logic [1:0] burst_lo;     // next low address bits of a burst
  logic      burst_init_q;  // a_i[0] of the last load
  nobl_cmd_t cmd_d;
  nobl_cmd_t cmd_q;

  // ********************************************************************
  // load decode
  // ********************************************************************

  assign sel = ~ce1_n_i & ce2_i & ~ce3_n_i;

  always_comb
  begin
    if (!sel)
    begin
      load_op   = OP_DESEL;
      load_mask = '0;
    end
    else if (!we_n_i)
    begin
      load_op   = OP_WRITE;
      load_mask = ~bws_n_i;  // pins are low active
    end
    else
    begin
      load_op   = OP_READ;
      load_mask = '0;        // reads carry no mask
    end
  end

  // ********************************************************************
  // burst address
  // ********************************************************************

  // an even start address always counts up, as in the linear order
  assign linear = ~mode_i | ~burst_init_q;

  always_comb
  begin
    if (linear)
      burst_lo = cmd_q.addr[1:0] + 2'd1;  // 0-1-2-3 wrap
    else
      burst_lo = cmd_q.addr[1:0] - 2'd1;  // odd start, interleaved steps down
  end

  always_comb
  begin
    if (!adv_ld_n_i)
    begin
      cmd_d.op    = load_op;
      cmd_d.addr  = a_i;
      cmd_d.bmask = load_mask;
    end
    else
    begin
      cmd_d           = cmd_q;     // op and mask repeat, deselect stays deselect
      cmd_d.addr[1:0] = burst_lo;  // upper bits fixed for the group
    end
  end

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cmd_q        <= '{op: OP_DESEL, addr: '0, bmask: '0};
      burst_init_q <= 1'b0;
    end
    else if (!cen_n_i)
    begin
      cmd_q <= cmd_d;
      if (!adv_ld_n_i)
        burst_init_q <= a_i[0];  // kept for the whole burst
    end
  end

  assign cmd_o = cmd_q;

endmodule

`default_nettype wire

/* src/nobl_pkg.sv */
/*
  Shared types of the NoBL SRAM. Widths come from nobl_defines.svh.
  Byte masks here are active high, unlike the bws_n_i pins.
*/
`default_nettype none

package nobl_pkg;

  `include "nobl_defines.svh"

  // ********************************************************************
  // vector types
  // ********************************************************************

  typedef logic [`NOBL_ADDR_W-1:0] addr_t;   // word address
  typedef logic [`NOBL_DATA_W-1:0] data_t;   // data word
  typedef logic [`NOBL_BYTES-1:0]  bmask_t;  // byte write mask, 1 = write lane

  // operation held by the decoder, repeated on burst cycles
  typedef enum logic [1:0] {
    OP_DESEL = 2'd0,  // chip not selected
    OP_READ  = 2'd1,
    OP_WRITE = 2'd2
  } nobl_op_e;

  // one registered command per enabled edge
  typedef struct packed {
    nobl_op_e op;
    addr_t    addr;
    bmask_t   bmask;  // zero for reads and deselects
  } nobl_cmd_t;

  // write request into the array, valid for one edge
  typedef struct packed {
    logic   en;
    addr_t  addr;
    bmask_t bmask;
    data_t  data;
  } wr_req_t;

endpackage

`default_nettype wire

/* src/nobl_defines.svh */
/*
  Geometry of the NoBL SRAM model: 1K words of two 9-bit byte lanes.
  NOBL_DATA_W must equal NOBL_BYTES * NOBL_BYTE_W.
*/
`ifndef NOBL_DEFINES_SVH
`define NOBL_DEFINES_SVH

// ********************************************************************
// array geometry
// ********************************************************************

`define NOBL_ADDR_W 10  // word address, 1K deep

`define NOBL_DATA_W 18  // full word

`define NOBL_BYTES  2   // byte lanes per word
`define NOBL_BYTE_W 9   // bits per lane, parity bit included

`endif
